//--- flist.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_core_pkg.sv
verilog/key_mux.sv
verilog/idu.sv
verilog/exu.sv
verilog/reg_file.sv
verilog/core_ctrl.sv
verilog/rv_core_top.sv
sim/tb_asserts.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the RV32I core testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_top -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

grep -q "PASS: all tests" sim.log

//--- sim/tb_asserts.sv
`timescale 1ns/1ps

module tb_asserts (
    input logic        clock,
    input logic        reset,
    input logic        mem_req_valid,
    input logic        mem_req_ready,
    input logic [31:0] mem_req_addr,
    input logic        retire_valid
);

    // a waiting request keeps valid and address until the handshake
    req_stable: assert property (@(posedge clock) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
        else $error("request dropped or address changed before handshake");

    retire_pulse: assert property (@(posedge clock) disable iff (reset)
        retire_valid |=> !retire_valid)
        else $error("retire_valid high on two consecutive cycles");

    reset_no_req: assert property (@(posedge clock)
        reset |-> !mem_req_valid)
        else $error("memory request raised during reset");

    reset_no_retire: assert property (@(posedge clock)
        reset |=> !retire_valid)
        else $error("retire_valid high during reset");

endmodule

//--- sim/tb_checker.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module tb_checker (
    input logic        clock,
    input logic        reset,
    input logic        retire_valid,
    input logic [31:0] retire_pc,
    input logic [4:0]  retire_rd,
    input logic        retire_we,
    input logic [31:0] retire_data
);

    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    int error_count = 0;
    int retire_count = 0;

    // one instruction of the reference model, straight from the ISA rules
    function automatic void exec_ref(input logic [31:0] pc, input logic [31:0] ins,
                                     output logic [4:0] rd, output logic we,
                                     output logic [31:0] data, output logic [31:0] npc);
        logic [31:0] a, b, imm_i, imm_u, imm_j, imm_b;
        a = ref_regs[ins[19:15]];
        b = ref_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'h000};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        rd = ins[11:7];
        we = 1'b0;
        data = '0;
        npc = pc + 32'd4;
        case (ins[6:0])
            7'h13: if (ins[14:12] == 3'd0) begin we = 1'b1; data = a + imm_i; end
            7'h37: begin we = 1'b1; data = imm_u; end
            7'h17: begin we = 1'b1; data = pc + imm_u; end
            7'h6f: begin we = 1'b1; data = pc + 32'd4; npc = pc + imm_j; end
            7'h67: if (ins[14:12] == 3'd0) begin
                we = 1'b1;
                data = pc + 32'd4;
                npc = (a + imm_i) & 32'hFFFF_FFFE;
            end
            7'h03: if (ins[14:12] == 3'd2) begin
                we = 1'b1;
                data = tb_top.mem[8'((a + imm_i) >> 2)]; // same word index as the model
            end
            7'h63: if (ins[14:12] == 3'd0 && a == b) npc = pc + imm_b;
            default: ;
        endcase
        if (rd == 5'd0) we = 1'b0;
    endfunction

    task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h (retirement %0d)",
                     name, got, exp, retire_count);
            error_count++;
        end
    endtask

    always @(posedge clock) begin
        logic [4:0] exp_rd;
        logic exp_we;
        logic [31:0] exp_data, exp_npc;
        if (reset) begin
            for (int i = 0; i < 32; i++) ref_regs[i] = '0;
            ref_pc = `RESET_PC;
            retire_count = 0;
        end else if (retire_valid) begin
            exec_ref(ref_pc, tb_top.mem[8'(ref_pc >> 2)], exp_rd, exp_we, exp_data, exp_npc);
            report("retire_pc", retire_pc, ref_pc);
            report("retire_rd", 32'(retire_rd), 32'(exp_rd));
            report("retire_we", 32'(retire_we), 32'(exp_we));
            if (exp_we) begin
                report("retire_data", retire_data, exp_data);
                ref_regs[exp_rd] = exp_data;
            end
            ref_pc = exp_npc; // follow the model, not the DUT
            retire_count++;
        end
    end

endmodule

//--- sim/tb_top.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module tb_top;

    localparam int TOTAL_RETIRES = 120;
    localparam int MAX_STALL = 14; // ready and response stalls, two accesses
    localparam int CYCLE_LIMIT = TOTAL_RETIRES * (6 + MAX_STALL) + 5 * 4 + 200;

    logic clock = 1'b0;
    logic reset = 1'b1;
    logic mem_req_valid;
    logic mem_req_ready = 1'b0;
    logic mem_rsp_valid = 1'b0;
    logic [31:0] mem_req_addr;
    logic [31:0] mem_rsp_data = '0;
    logic retire_valid, retire_we;
    logic [31:0] retire_pc, retire_data;
    logic [4:0] retire_rd;

    logic [31:0] mem [256];
    logic [15:0] lfsr_state = 16'd23185;
    logic pending = 1'b0;
    logic [7:0] pend_idx;
    logic [1:0] delay, low_run;
    int cycles = 0;
    int tests_failed = 0;
    int test_num = 0;

    always #20 clock = ~clock;

    rv_core_top dut_i (.*);

    tb_checker chk_i (.*);

    bind rv_core_top tb_asserts asserts_i (.*);

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_i(logic [6:0] opc, logic [4:0] rd, logic [2:0] f3,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [31:0] enc_b(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'h63};
    endfunction

    // memory with random ready and response delay
    always @(posedge clock) begin
        logic hs;
        logic rst_s;
        logic [7:0] hs_idx;
        rst_s = reset; // reset as seen at the edge
        hs = mem_req_valid && mem_req_ready && !rst_s;
        hs_idx = mem_req_addr[9:2];
        #1;
        if (rst_s) begin
            mem_req_ready = 1'b0;
            mem_rsp_valid = 1'b0;
            pending = 1'b0;
            low_run = '0;
        end else begin
            mem_rsp_valid = 1'b0;
            if (hs) begin
                pending = 1'b1;
                pend_idx = hs_idx;
                delay = 2'(take_bits(2));
            end
            if (pending) begin
                if (delay == 2'd0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data = mem[pend_idx];
                    pending = 1'b0;
                end else begin
                    delay = delay - 2'd1;
                end
            end
            if (pending || hs) begin
                mem_req_ready = 1'b0;
            end else if (low_run == 2'd3) begin
                mem_req_ready = 1'b1;
                low_run = '0;
            end else begin
                mem_req_ready = (take_bits(2) != 32'd0);
                low_run = mem_req_ready ? 2'd0 : low_run + 2'd1;
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the core stopped retiring after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic clear_memory();
        for (int i = 0; i < 128; i++) mem[i] = 32'h0000_0013; // nop
        mem[127] = enc_j(5'd0, 21'h1FFE04); // back to word 0
        for (int i = 128; i < 256; i++) mem[i] = (32'(i) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    endtask

    task automatic hold_reset();
        #1 reset = 1'b1;
        repeat (3) @(posedge clock);
    endtask

    task automatic run_test(input string name, input int n_retire);
        int errs_before;
        errs_before = chk_i.error_count;
        test_num++;
        #1 reset = 1'b0;
        do begin
            @(posedge clock);
            #1;
        end while (chk_i.retire_count < n_retire);
        reset = 1'b1;
        if (chk_i.error_count != errs_before) tests_failed++;
        $display("test %0d %s: %0d retirements, %0d errors", test_num, name,
                 chk_i.retire_count, chk_i.error_count - errs_before);
    endtask

    task automatic build_random_program(input int len);
        logic [2:0] sel;
        for (int i = 0; i < len; i++) begin
            sel = 3'(take_bits(3));
            case (sel)
                3'd0, 3'd1: mem[i] = enc_i(7'h13, 5'(take_bits(5)), 3'd0, 5'(take_bits(5)),
                                           12'(take_bits(12)));
                3'd2: mem[i] = enc_u(7'h37, 5'(take_bits(5)), 20'(take_bits(20)));
                3'd3: mem[i] = enc_u(7'h17, 5'(take_bits(5)), 20'(take_bits(20)));
                3'd4: mem[i] = enc_i(7'h03, 5'(take_bits(5)), 3'd2, 5'd0,
                                     12'(32'h200 + 4 * take_bits(5)));
                3'd5: mem[i] = enc_b(5'(take_bits(2)), 5'(take_bits(2)),
                                     13'(4 * (1 + take_bits(3))));
                3'd6: mem[i] = enc_j(5'(take_bits(5)), 21'(4 * (1 + take_bits(2))));
                default: begin
                    if (take_bits(1) == 32'd1) begin
                        mem[i] = {25'(take_bits(25)), 7'b0110011}; // unsupported OP
                    end else begin
                        // jalr forward with a possibly odd target
                        mem[i] = enc_i(7'h67, 5'(take_bits(5)), 3'd0, 5'd0,
                                       12'(4 * (i + 1 + int'(take_bits(2))) + int'(take_bits(1))));
                    end
                end
            endcase
        end
    endtask

    initial begin
        hold_reset();
        clear_memory();
        mem[0] = enc_i(7'h13, 5'd1, 3'd0, 5'd0, 12'd5);
        mem[1] = enc_i(7'h13, 5'd2, 3'd0, 5'd1, 12'hFFD);
        mem[2] = enc_u(7'h37, 5'd3, 20'h12345);
        mem[3] = enc_u(7'h17, 5'd4, 20'h00001);
        mem[4] = enc_i(7'h13, 5'd0, 3'd0, 5'd1, 12'd7);
        mem[5] = enc_i(7'h13, 5'd5, 3'd0, 5'd0, 12'd0);
        run_test("addi lui auipc", 6);

        hold_reset();
        clear_memory();
        mem[0] = enc_i(7'h13, 5'd1, 3'd0, 5'd0, 12'h200);
        mem[1] = enc_i(7'h03, 5'd2, 3'd2, 5'd1, 12'd4);
        mem[2] = enc_i(7'h03, 5'd3, 3'd2, 5'd1, 12'hFFC);
        mem[3] = enc_i(7'h03, 5'd4, 3'd2, 5'd0, 12'h208);
        run_test("lw", 4);

        hold_reset();
        clear_memory();
        mem[0] = enc_i(7'h13, 5'd1, 3'd0, 5'd0, 12'd1);
        mem[1] = enc_i(7'h13, 5'd2, 3'd0, 5'd0, 12'd1);
        mem[2] = enc_b(5'd1, 5'd2, 13'd8);
        mem[3] = enc_i(7'h13, 5'd3, 3'd0, 5'd0, 12'd9);
        mem[4] = enc_i(7'h13, 5'd4, 3'd0, 5'd0, 12'd4);
        mem[5] = enc_b(5'd1, 5'd0, 13'd8);
        mem[6] = enc_i(7'h13, 5'd5, 3'd0, 5'd0, 12'd5);
        run_test("beq", 6);

        hold_reset();
        clear_memory();
        mem[0] = enc_j(5'd1, 21'd8);
        mem[2] = enc_i(7'h13, 5'd2, 3'd0, 5'd0, 12'h011);
        mem[3] = enc_i(7'h67, 5'd3, 3'd0, 5'd2, 12'd0); // lands on word 4
        mem[4] = enc_i(7'h13, 5'd4, 3'd0, 5'd0, 12'd1);
        run_test("jal jalr", 4);

        hold_reset();
        clear_memory();
        build_random_program(40);
        run_test("random program", 100);

        $display("tests: %0d run, %0d failed, %0d errors",
                 test_num, tests_failed, chk_i.error_count);
        if (tests_failed == 0 && chk_i.error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verilog/core_ctrl.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module core_ctrl (
    input  logic                 clock,
    input  logic                 reset,
    output logic                 mem_req_valid,
    input  logic                 mem_req_ready,
    output logic [`XLEN-1:0]     mem_req_addr,
    input  logic                 mem_rsp_valid,
    input  logic [`XLEN-1:0]     mem_rsp_data,
    input  rv_core_pkg::exu_op_e op,
    input  logic                 writes_rd,
    input  logic [4:0]           rd,
    input  logic [`XLEN-1:0]     result,
    input  logic [`XLEN-1:0]     next_pc,
    output logic [`XLEN-1:0]     instr,
    output logic [`XLEN-1:0]     pc,
    output logic [`XLEN-1:0]     load_data,
    output logic                 retire_valid,
    output logic [`XLEN-1:0]     retire_pc,
    output logic [4:0]           retire_rd,
    output logic                 retire_we,
    output logic [`XLEN-1:0]     retire_data
);

    rv_core_pkg::ctrl_state_e state_q;
    logic [`XLEN-1:0] pc_q, instr_q, load_data_q, result_q, next_pc_q;
    logic is_lw;

    assign is_lw = (op == rv_core_pkg::EXU_LW);

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= rv_core_pkg::ST_FETCH;
            pc_q <= `RESET_PC;
        end else begin
            case (state_q)
                rv_core_pkg::ST_FETCH:
                    if (mem_req_ready) state_q <= rv_core_pkg::ST_FETCH_WAIT;
                rv_core_pkg::ST_FETCH_WAIT:
                    if (mem_rsp_valid) state_q <= rv_core_pkg::ST_EXEC;
                rv_core_pkg::ST_EXEC:
                    state_q <= is_lw ? rv_core_pkg::ST_LOAD : rv_core_pkg::ST_RETIRE;
                rv_core_pkg::ST_LOAD:
                    if (mem_req_ready) state_q <= rv_core_pkg::ST_LOAD_WAIT;
                rv_core_pkg::ST_LOAD_WAIT:
                    if (mem_rsp_valid) state_q <= rv_core_pkg::ST_RETIRE;
                default: begin // retire
                    pc_q <= is_lw ? pc_q + 32'd4 : next_pc_q;
                    state_q <= rv_core_pkg::ST_FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state_q == rv_core_pkg::ST_FETCH_WAIT && mem_rsp_valid) instr_q <= mem_rsp_data;
        if (state_q == rv_core_pkg::ST_LOAD_WAIT && mem_rsp_valid) load_data_q <= mem_rsp_data;
        if (state_q == rv_core_pkg::ST_EXEC) begin
            result_q <= result;
            next_pc_q <= next_pc;
        end
    end

    // bus stays idle while reset is held
    assign mem_req_valid = !reset && ((state_q == rv_core_pkg::ST_FETCH) ||
                                      (state_q == rv_core_pkg::ST_LOAD));
    assign mem_req_addr = (state_q == rv_core_pkg::ST_LOAD) ? next_pc_q : pc_q;

    assign instr = instr_q;
    assign pc = pc_q;
    assign load_data = load_data_q;

    assign retire_valid = (state_q == rv_core_pkg::ST_RETIRE);
    assign retire_pc = pc_q;
    assign retire_rd = rd;
    assign retire_we = retire_valid && writes_rd;
    assign retire_data = is_lw ? result : result_q; // lw result follows load_data

endmodule

//--- verilog/exu.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module exu (
    input  rv_core_pkg::exu_op_e op,
    input  logic [`XLEN-1:0]     rs1_data,
    input  logic [`XLEN-1:0]     rs2_data,
    input  logic [`XLEN-1:0]     imm,
    input  logic [`XLEN-1:0]     pc,
    input  logic [`XLEN-1:0]     load_data,
    output logic [`XLEN-1:0]     result,
    output logic [`XLEN-1:0]     next_pc
);

    typedef logic [`XLEN-1:0] word_t;

    word_t alu_a, sum, pc_plus4, branch_target, beq_next;
    logic [2:0] a_keys [3];
    word_t a_values [3];
    logic [2:0] res_keys [3];
    word_t res_values [3];
    logic [2:0] pc_keys [4];
    word_t pc_values [4];

    assign a_keys = '{rv_core_pkg::EXU_AUIPC, rv_core_pkg::EXU_LUI, rv_core_pkg::EXU_JAL};
    assign a_values = '{pc, '0, pc};

    key_mux #(.N(3), .KEY_W(3), .T(word_t)) alu_a_mux (
        .key(op), .default_out(rs1_data), .keys(a_keys), .values(a_values), .out(alu_a)
    );

    assign sum = alu_a + imm;
    assign pc_plus4 = pc + 32'd4;
    assign branch_target = pc + imm;
    assign beq_next = (rs1_data == rs2_data) ? branch_target : pc_plus4;

    assign res_keys = '{rv_core_pkg::EXU_JAL, rv_core_pkg::EXU_JALR, rv_core_pkg::EXU_LW};
    assign res_values = '{pc_plus4, pc_plus4, load_data}; // link address or loaded word

    key_mux #(.N(3), .KEY_W(3), .T(word_t)) result_mux (
        .key(op), .default_out(sum), .keys(res_keys), .values(res_values), .out(result)
    );

    // lw hands its access address out here, core_ctrl steps pc by 4 itself
    assign pc_keys = '{rv_core_pkg::EXU_JAL, rv_core_pkg::EXU_JALR, rv_core_pkg::EXU_BEQ,
                       rv_core_pkg::EXU_LW};
    assign pc_values = '{sum, {sum[`XLEN-1:1], 1'b0}, beq_next, sum};

    key_mux #(.N(4), .KEY_W(3), .T(word_t)) next_pc_mux (
        .key(op), .default_out(pc_plus4), .keys(pc_keys), .values(pc_values), .out(next_pc)
    );

endmodule

//--- verilog/idu.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module idu (
    input  logic [`XLEN-1:0]      instr,
    output rv_core_pkg::exu_op_e  op,
    output logic [4:0]            rs1,
    output logic [4:0]            rs2,
    output logic [4:0]            rd,
    output logic [`XLEN-1:0]      imm,
    output logic                  writes_rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [2:0] f3_key;
    rv_isa_pkg::imm_fmt_e fmt;
    logic [6:0] fmt_keys [7];
    rv_isa_pkg::imm_fmt_e fmt_values [7];
    logic [9:0] op_keys [7];
    rv_core_pkg::exu_op_e op_values [7];

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd = instr[11:7];

    assign fmt_keys = '{rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_JALR, rv_isa_pkg::OP_LOAD,
                        rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC, rv_isa_pkg::OP_JAL,
                        rv_isa_pkg::OP_BRANCH};
    assign fmt_values = '{rv_isa_pkg::IMM_I, rv_isa_pkg::IMM_I, rv_isa_pkg::IMM_I,
                          rv_isa_pkg::IMM_U, rv_isa_pkg::IMM_U, rv_isa_pkg::IMM_J,
                          rv_isa_pkg::IMM_B};

    key_mux #(.N(7), .KEY_W(7), .T(rv_isa_pkg::imm_fmt_e)) fmt_mux (
        .key(opcode), .default_out(rv_isa_pkg::IMM_NONE),
        .keys(fmt_keys), .values(fmt_values), .out(fmt)
    );

    // U and J formats carry no funct3
    assign f3_key = (fmt == rv_isa_pkg::IMM_I || fmt == rv_isa_pkg::IMM_B) ? funct3 : 3'b000;

    assign op_keys = '{{rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADDI}, {rv_isa_pkg::OP_LUI, 3'b000},
                       {rv_isa_pkg::OP_AUIPC, 3'b000}, {rv_isa_pkg::OP_JAL, 3'b000},
                       {rv_isa_pkg::OP_JALR, 3'b000}, {rv_isa_pkg::OP_LOAD, rv_isa_pkg::F3_LW},
                       {rv_isa_pkg::OP_BRANCH, rv_isa_pkg::F3_BEQ}};
    assign op_values = '{rv_core_pkg::EXU_ADD, rv_core_pkg::EXU_LUI, rv_core_pkg::EXU_AUIPC,
                         rv_core_pkg::EXU_JAL, rv_core_pkg::EXU_JALR, rv_core_pkg::EXU_LW,
                         rv_core_pkg::EXU_BEQ};

    key_mux #(.N(7), .KEY_W(10), .T(rv_core_pkg::exu_op_e)) op_mux (
        .key({opcode, f3_key}), .default_out(rv_core_pkg::EXU_NOP),
        .keys(op_keys), .values(op_values), .out(op)
    );

    always_comb begin
        case (fmt)
            rv_isa_pkg::IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            rv_isa_pkg::IMM_U: imm = {instr[31:12], 12'b0};
            rv_isa_pkg::IMM_J: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            rv_isa_pkg::IMM_B: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            default:           imm = '0;
        endcase
    end

    assign writes_rd = (op != rv_core_pkg::EXU_BEQ) && (op != rv_core_pkg::EXU_NOP) && (rd != 5'd0);

endmodule

//--- verilog/key_mux.sv
`timescale 1ns/1ps

module key_mux #(
    parameter int N = 2,
    parameter int KEY_W = 1,
    parameter type T = logic [31:0]
) (
    input  logic [KEY_W-1:0] key,
    input  T                 default_out,
    input  logic [KEY_W-1:0] keys [N],
    input  T                 values [N],
    output T                 out
);

    always_comb begin
        logic found;
        found = 1'b0;
        out = default_out;
        for (int i = 0; i < N; i++) begin
            if (!found && key == keys[i]) begin // first match wins
                out = values[i];
                found = 1'b1;
            end
        end
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module reg_file (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [$clog2(`REG_COUNT)-1:0] rs1,
    input  logic [$clog2(`REG_COUNT)-1:0] rs2,
    input  logic [$clog2(`REG_COUNT)-1:0] rd,
    input  logic                          we,
    input  logic [`XLEN-1:0]              wdata,
    output logic [`XLEN-1:0]              rs1_data,
    output logic [`XLEN-1:0]              rs2_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

//--- verilog/rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// data and address width
`define XLEN 32

// architectural registers, x0 included
`define REG_COUNT 32

// first fetch address
`define RESET_PC 32'h0000_0000

`endif

//--- verilog/rv_core_pkg.sv
package rv_core_pkg;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_FETCH_WAIT,
        ST_EXEC,
        ST_LOAD,
        ST_LOAD_WAIT,
        ST_RETIRE
    } ctrl_state_e;

    // what exu does with the decoded instruction
    typedef enum logic [2:0] {
        EXU_ADD,
        EXU_LUI,
        EXU_AUIPC,
        EXU_JAL,
        EXU_JALR,
        EXU_LW,
        EXU_BEQ,
        EXU_NOP
    } exu_op_e;

endpackage

//--- verilog/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_core_top (
    input  logic             clock,
    input  logic             reset,
    output logic             mem_req_valid,
    input  logic             mem_req_ready,
    output logic [`XLEN-1:0] mem_req_addr,
    input  logic             mem_rsp_valid,
    input  logic [`XLEN-1:0] mem_rsp_data,
    output logic             retire_valid,
    output logic [`XLEN-1:0] retire_pc,
    output logic [4:0]       retire_rd,
    output logic             retire_we,
    output logic [`XLEN-1:0] retire_data
);

    rv_core_pkg::exu_op_e op;
    logic [`XLEN-1:0] instr, pc, load_data, imm;
    logic [`XLEN-1:0] rs1_data, rs2_data, result, next_pc;
    logic [4:0] rs1, rs2, rd;
    logic writes_rd;

    core_ctrl ctrl_i (
        .clock(clock), .reset(reset),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_req_addr(mem_req_addr), .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_data(mem_rsp_data), .op(op), .writes_rd(writes_rd), .rd(rd),
        .result(result), .next_pc(next_pc), .instr(instr), .pc(pc), .load_data(load_data),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_data(retire_data)
    );

    idu idu_i (
        .instr(instr), .op(op), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .writes_rd(writes_rd)
    );

    reg_file regs_i (
        .clock(clock), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(retire_rd),
        .we(retire_we), .wdata(retire_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    exu exu_i (
        .op(op), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .pc(pc),
        .load_data(load_data), .result(result), .next_pc(next_pc)
    );

endmodule

//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LOAD   = 7'b0000011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    localparam logic [2:0] F3_ADDI = 3'b000;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_BEQ  = 3'b000;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_U,
        IMM_J,
        IMM_B
    } imm_fmt_e;

endpackage
